/* verif/obi_integ_checker.sv */
module obi_integ_checker (
    input logic clk_i,
    input logic rst_i,
    // Instruction port handshake
    input logic instr_req_i,
    input logic instr_gnt_i,
    input logic instr_gntpar_i,
    input logic instr_rvalid_i,
    input logic instr_rvalidpar_i,
    // Data port handshake
    input logic data_req_i,
    input logic data_gnt_i,
    input logic data_gntpar_i,
    input logic data_rvalid_i,
    input logic data_rvalidpar_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------
    // Strobe parity
    // --------------------------------------------------
    a_instr_gntpar: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_gntpar_i == ~instr_gnt_i) else $error("instr gntpar not inverse of gnt");
    a_data_gntpar: assert property (@(posedge clk_i) disable iff (rst_i)
        data_gntpar_i == ~data_gnt_i) else $error("data gntpar not inverse of gnt");
    a_instr_rvalidpar: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalidpar_i == ~instr_rvalid_i) else $error("instr rvalidpar not inverse");
    a_data_rvalidpar: assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalidpar_i == ~data_rvalid_i) else $error("data rvalidpar not inverse");

    // --------------------------------------------------
    // Response timing
    // --------------------------------------------------

    // Accepted request answered on the next cycle
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        (instr_req_i && instr_gnt_i) |=> instr_rvalid_i) else $error("instr rvalid missing");
    a_data_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
        (data_req_i && data_gnt_i) |=> data_rvalid_i) else $error("data rvalid missing");
    // No response without a grant just before it
    a_instr_no_stray: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_rvalid_i |-> $past(instr_gnt_i)) else $error("instr rvalid without grant");
    a_data_no_stray: assert property (@(posedge clk_i) disable iff (rst_i)
        data_rvalid_i |-> $past(data_gnt_i)) else $error("data rvalid without grant");

    // Single ported memory, one winner per cycle
    a_one_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        !(instr_gnt_i && data_gnt_i)) else $error("both ports granted");

endmodule

bind obi_integ_top obi_integ_checker integ_chk_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .instr_req_i       (instr_req_i),
    .instr_gnt_i       (instr_gnt_o),
    .instr_gntpar_i    (instr_gntpar_o),
    .instr_rvalid_i    (instr_rvalid_o),
    .instr_rvalidpar_i (instr_rvalidpar_o),
    .data_req_i        (data_req_i),
    .data_gnt_i        (data_gnt_o),
    .data_gntpar_i     (data_gntpar_o),
    .data_rvalid_i     (data_rvalid_o),
    .data_rvalidpar_i  (data_rvalidpar_o)
);

/* verif/obi_integ_tb.sv */
`include "obi_integ_config.svh"

module obi_integ_tb
    import obi_integ_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH   = 1 << `OBI_MEM_AW;
    localparam int TIMEOUT = 50;

    logic      clk;
    logic      rst;
    logic      instr_req, instr_reqpar, instr_gnt, instr_gntpar, instr_rvalid, instr_rvalidpar;
    logic      data_req, data_reqpar, data_gnt, data_gntpar, data_rvalid, data_rvalidpar;
    obi_req_t  instr_a, data_a;
    obi_achk_t instr_achk, data_achk;
    obi_rsp_t  instr_r, data_r;
    obi_rchk_t instr_rchk, data_rchk;
    logic      alert_major, alert_minor;

    // Reference memory and expected responses per port
    logic [31:0] model [0:DEPTH-1];
    obi_rsp_t    instr_exp_q [$];
    obi_rsp_t    data_exp_q [$];
    int          checks = 0;
    int          errors = 0;
    int          major_cnt = 0;
    int          minor_cnt = 0;
    int          cycle = 0;
    bit          timed_out = 0;

    obi_integ_top obi_integ_top_i (
        .clk_i (clk), .rst_i (rst),
        .instr_req_i (instr_req), .instr_reqpar_i (instr_reqpar), .instr_a_i (instr_a),
        .instr_achk_i (instr_achk), .instr_gnt_o (instr_gnt), .instr_gntpar_o (instr_gntpar),
        .instr_rvalid_o (instr_rvalid), .instr_rvalidpar_o (instr_rvalidpar),
        .instr_r_o (instr_r), .instr_rchk_o (instr_rchk),
        .data_req_i (data_req), .data_reqpar_i (data_reqpar), .data_a_i (data_a),
        .data_achk_i (data_achk), .data_gnt_o (data_gnt), .data_gntpar_o (data_gntpar),
        .data_rvalid_o (data_rvalid), .data_rvalidpar_o (data_rvalidpar),
        .data_r_o (data_r), .data_rchk_o (data_rchk),
        .alert_major_o (alert_major), .alert_minor_o (alert_minor)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic obi_achk_t calc_achk(obi_req_t a);
        obi_achk_t c;
        for (int b = 0; b < 4; b++) c[b] = ^a.addr[8*b +: 8];
        c[4] = ^{a.we, a.be};
        c[5] = ^a.wdata;
        return c;
    endfunction

    function automatic obi_rchk_t calc_rchk(obi_rsp_t r);
        obi_rchk_t c;
        for (int b = 0; b < 4; b++) c[b] = ^r.rdata[8*b +: 8];
        c[4] = r.err;
        return c;
    endfunction

    function automatic bit addr_in_range(logic [31:0] addr);
        return (addr >> (`OBI_MEM_AW + 2)) == 0;
    endfunction

    // Old contents on a good access, zero data with err otherwise
    function automatic obi_rsp_t expect_rsp(obi_req_t a, bit bad);
        obi_rsp_t r;
        if (bad || !addr_in_range(a.addr)) begin
            r.rdata = '0;
            r.err   = 1'b1;
        end else begin
            r.rdata = model[a.addr[`OBI_MEM_AW+1:2]];
            r.err   = 1'b0;
        end
        return r;
    endfunction

    task automatic model_write(obi_req_t a, bit bad);
        if (a.we && !bad && addr_in_range(a.addr)) begin
            for (int b = 0; b < 4; b++)
                if (a.be[b]) model[a.addr[`OBI_MEM_AW+1:2]][8*b +: 8] = a.wdata[8*b +: 8];
        end
    endtask

    // --------------------------------------------------
    // Checking and reporting
    // --------------------------------------------------
    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_rsp(string port, obi_rsp_t got, obi_rchk_t got_chk, obi_rsp_t exp);
        check({port, " rdata"}, got.rdata, exp.rdata);
        check({port, " err"}, got.err, exp.err);
        check({port, " rchk"}, got_chk, calc_rchk(exp));
    endtask

    task automatic note_timeout(string what);
        timed_out = 1;
        errors++;
        $display("ERROR: timed out waiting for %s", what);
    endtask

    task automatic report_test(int num, string name, int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
    endtask

    // Grant strobes settle from inputs driven at the falling edge
    always @(posedge clk) begin
        if (!rst) begin
            check("instr_gntpar", instr_gntpar, !instr_gnt);
            check("data_gntpar", data_gntpar, !data_gnt);
            // Single ported memory, at most one grant
            check("gnt both ports", instr_gnt & data_gnt, 1'b0);
        end
    end

    // Responses and alerts are registered, so stable at the falling edge
    always @(negedge clk) begin
        cycle <= cycle + 1;
        if (!rst) begin
            if (alert_major) major_cnt++;
            if (alert_minor) minor_cnt++;
            check("instr_rvalidpar", instr_rvalidpar, !instr_rvalid);
            check("data_rvalidpar", data_rvalidpar, !data_rvalid);
            if (instr_rvalid && instr_exp_q.size() == 0) begin
                errors++;
                $display("ERROR: instr response arrived with no request outstanding");
            end else if (instr_rvalid) begin
                compare_rsp("instr", instr_r, instr_rchk, instr_exp_q.pop_front());
            end
            if (data_rvalid && data_exp_q.size() == 0) begin
                errors++;
                $display("ERROR: data response arrived with no request outstanding");
            end else if (data_rvalid) begin
                compare_rsp("data", data_r, data_rchk, data_exp_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic drive_port(bit port, logic req, logic reqpar, obi_req_t a, obi_achk_t achk);
        if (port) begin
            data_req    = req;
            data_reqpar = reqpar;
            data_a      = a;
            data_achk   = achk;
        end else begin
            instr_req    = req;
            instr_reqpar = reqpar;
            instr_a      = a;
            instr_achk   = achk;
        end
    endtask

    // One full OBI transaction, optionally with corrupted check bits or parity
    task automatic issue(bit port, obi_req_t a, obi_achk_t achk_flip, bit par_flip,
                         output int gnt_cyc);
        int waited;
        bit bad;
        bad = (achk_flip != '0) || par_flip;
        gnt_cyc = -1;
        if (timed_out) return;
        @(negedge clk);
        drive_port(port, 1'b1, par_flip, a, calc_achk(a) ^ achk_flip);
        // gnt is combinational from inputs settled since the falling edge
        waited = 0;
        @(posedge clk);
        while (!(port ? data_gnt : instr_gnt) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!(port ? data_gnt : instr_gnt)) begin
            note_timeout(port ? "data gnt" : "instr gnt");
            return;
        end
        if (port) data_exp_q.push_back(expect_rsp(a, bad));
        else instr_exp_q.push_back(expect_rsp(a, bad));
        model_write(a, bad);
        gnt_cyc = cycle;
        @(negedge clk);
        drive_port(port, 1'b0, 1'b1, '0, '0);
        waited = 0;
        while (!(port ? data_rvalid : instr_rvalid) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!(port ? data_rvalid : instr_rvalid)) begin
            note_timeout(port ? "data rvalid" : "instr rvalid");
        end
    endtask

    task automatic idle(int n);
        repeat (n) @(posedge clk);
    endtask

    initial begin
        obi_req_t    a;
        obi_req_t    ra;
        logic [31:0] addr_list [0:7];
        int          dc, ic, e0, maj0, min0;
        void'($urandom(32'haeeae199));
        clk = 1'b0;
        rst = 1'b1;
        drive_port(1'b0, 1'b0, 1'b1, '0, '0);
        drive_port(1'b1, 1'b0, 1'b1, '0, '0);
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Full word then random byte enables then read back
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = ($urandom % DEPTH) << 2;
            a = '{addr: addr_list[i], we: 1'b1, be: 4'hf, wdata: $urandom};
            issue(1'b1, a, '0, 1'b0, dc);
            a.be = $urandom % 16;
            a.wdata = $urandom;
            issue(1'b1, a, '0, 1'b0, dc);
            a.we = 1'b0;
            issue(1'b1, a, '0, 1'b0, dc);
        end
        idle(2);
        report_test(1, "data write and read", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = '{addr: addr_list[i], we: 1'b0, be: 4'hf, wdata: '0};
            issue(1'b0, a, '0, 1'b0, ic);
        end
        idle(2);
        report_test(2, "instr reads", e0);

        e0 = errors;
        maj0 = major_cnt;
        min0 = minor_cnt;
        a = '{addr: 32'h8000_0000 | addr_list[0], we: 1'b1, be: 4'hf, wdata: $urandom};
        issue(1'b1, a, '0, 1'b0, dc);
        a = '{addr: addr_list[0], we: 1'b0, be: 4'hf, wdata: '0};
        issue(1'b1, a, '0, 1'b0, dc);
        idle(2);
        check("alert_major pulses", major_cnt - maj0, 0);
        check("alert_minor pulses", minor_cnt - min0, 0);
        report_test(3, "out of range", e0);

        // Corrupted achk must not reach the memory
        e0 = errors;
        maj0 = major_cnt;
        min0 = minor_cnt;
        a = '{addr: addr_list[1], we: 1'b1, be: 4'hf, wdata: $urandom};
        issue(1'b1, a, 6'h20, 1'b0, dc);
        idle(2);
        check("alert_minor pulses", minor_cnt - min0, 1);
        check("alert_major pulses", major_cnt - maj0, 0);
        a.we = 1'b0;
        issue(1'b1, a, '0, 1'b0, dc);
        idle(2);
        report_test(4, "achk fault", e0);

        // Bare parity fault first, then a request carrying it
        e0 = errors;
        maj0 = major_cnt;
        @(negedge clk);
        instr_reqpar = 1'b0;
        @(negedge clk);
        instr_reqpar = 1'b1;
        idle(2);
        check("alert_major pulses", major_cnt - maj0, 1);
        a = '{addr: addr_list[2], we: 1'b0, be: 4'hf, wdata: '0};
        issue(1'b0, a, '0, 1'b1, ic);
        idle(2);
        check("alert_major pulses", major_cnt - maj0, 2);
        report_test(5, "reqpar fault", e0);

        // Data wins, instr follows and sees the new word
        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            a = '{addr: addr_list[i + 3], we: 1'b1, be: 4'hf, wdata: $urandom};
            ra = '{addr: addr_list[i + 3], we: 1'b0, be: 4'hf, wdata: '0};
            fork
                issue(1'b1, a, '0, 1'b0, dc);
                issue(1'b0, ra, '0, 1'b0, ic);
            join
            check("grant order", ic > dc, 1);
        end
        idle(2);
        report_test(6, "simultaneous requests", e0);

        check("instr pending", instr_exp_q.size(), 0);
        check("data pending", data_exp_q.size(), 0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/obi_integ_pkg.sv
verilog/obi_req_checker.sv
verilog/obi_port_arbiter.sv
verilog/obi_sram.sv
verilog/obi_rsp_encoder.sv
verilog/obi_integ_top.sv
verif/obi_integ_checker.sv
verif/obi_integ_tb.sv

/* verilog/obi_integ_config.svh */
`ifndef OBI_INTEG_CONFIG_SVH
`define OBI_INTEG_CONFIG_SVH

// --------------------------------------------------
// Memory geometry
// --------------------------------------------------

// Memory depth as log2 of the word count, 256 words by default
`define OBI_MEM_AW 8

// --------------------------------------------------
// Bus geometry
// --------------------------------------------------

// OBI address width in bits
`define OBI_ADDR_W 32

`endif

/* verilog/obi_integ_pkg.sv */
package obi_integ_pkg;

`include "obi_integ_config.svh"

    // --------------------------------------------------
    // Address phase of one OBI request
    // --------------------------------------------------
    typedef struct packed {
        // Byte address from the requester
        logic [`OBI_ADDR_W-1:0] addr;
        // Write enable, low for reads
        logic                   we;
        // One enable per byte lane
        logic [3:0]             be;
        // Write payload
        logic [31:0]            wdata;
    } obi_req_t;

    // Address-phase check bits
    // Bits 3..0 are address byte parity, bit 4 covers we and be, bit 5 covers wdata
    typedef logic [5:0] obi_achk_t;

    // --------------------------------------------------
    // Response phase
    // --------------------------------------------------
    typedef struct packed {
        logic [31:0] rdata;
        // Error flag for range, check or parity faults
        logic        err;
    } obi_rsp_t;

    // Response check bits
    // Bits 3..0 are rdata byte parity, bit 4 mirrors err
    typedef logic [4:0] obi_rchk_t;

    // One memory word, seen whole or per byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } obi_word_u;

endpackage

/* verilog/obi_integ_top.sv */
module obi_integ_top
    import obi_integ_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Instruction port
    input  logic      instr_req_i,
    input  logic      instr_reqpar_i,
    input  obi_req_t  instr_a_i,
    input  obi_achk_t instr_achk_i,
    output logic      instr_gnt_o,
    output logic      instr_gntpar_o,
    output logic      instr_rvalid_o,
    output logic      instr_rvalidpar_o,
    output obi_rsp_t  instr_r_o,
    output obi_rchk_t instr_rchk_o,
    // Data port
    input  logic      data_req_i,
    input  logic      data_reqpar_i,
    input  obi_req_t  data_a_i,
    input  obi_achk_t data_achk_i,
    output logic      data_gnt_o,
    output logic      data_gntpar_o,
    output logic      data_rvalid_o,
    output logic      data_rvalidpar_o,
    output obi_rsp_t  data_r_o,
    output obi_rchk_t data_rchk_o,
    // Integrity alerts
    output logic      alert_major_o,
    output logic      alert_minor_o
);

    logic     instr_bad;
    logic     data_bad;
    logic     instr_alert_major;
    logic     instr_alert_minor;
    logic     data_alert_major;
    logic     data_alert_minor;
    logic     mem_en;
    logic     mem_suppress;
    obi_req_t mem_a;
    obi_rsp_t mem_rsp;

    // --------------------------------------------------
    // Request checks
    // --------------------------------------------------
    obi_req_checker instr_chk_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (instr_req_i),
        .reqpar_i      (instr_reqpar_i),
        .a_i           (instr_a_i),
        .achk_i        (instr_achk_i),
        .req_bad_o     (instr_bad),
        .alert_major_o (instr_alert_major),
        .alert_minor_o (instr_alert_minor)
    );

    obi_req_checker data_chk_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (data_req_i),
        .reqpar_i      (data_reqpar_i),
        .a_i           (data_a_i),
        .achk_i        (data_achk_i),
        .req_bad_o     (data_bad),
        .alert_major_o (data_alert_major),
        .alert_minor_o (data_alert_minor)
    );

    // Either port can raise an alert
    assign alert_major_o = instr_alert_major | data_alert_major;
    assign alert_minor_o = instr_alert_minor | data_alert_minor;

    // --------------------------------------------------
    // Arbitration and memory
    // --------------------------------------------------
    obi_port_arbiter arb_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_req_i    (instr_req_i),
        .instr_bad_i    (instr_bad),
        .instr_a_i      (instr_a_i),
        .data_req_i     (data_req_i),
        .data_bad_i     (data_bad),
        .data_a_i       (data_a_i),
        .instr_gnt_o    (instr_gnt_o),
        .data_gnt_o     (data_gnt_o),
        .mem_en_o       (mem_en),
        .mem_suppress_o (mem_suppress),
        .mem_a_o        (mem_a),
        .mem_rsp_i      (mem_rsp),
        .instr_rvalid_o (instr_rvalid_o),
        .data_rvalid_o  (data_rvalid_o),
        .instr_r_o      (instr_r_o),
        .data_r_o       (data_r_o)
    );

    obi_sram sram_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (mem_en),
        .suppress_i (mem_suppress),
        .a_i        (mem_a),
        .rsp_o      (mem_rsp)
    );

    // --------------------------------------------------
    // Response integrity
    // --------------------------------------------------
    obi_rsp_encoder instr_enc_i (
        .gnt_i       (instr_gnt_o),
        .rvalid_i    (instr_rvalid_o),
        .r_i         (instr_r_o),
        .gntpar_o    (instr_gntpar_o),
        .rvalidpar_o (instr_rvalidpar_o),
        .rchk_o      (instr_rchk_o)
    );

    obi_rsp_encoder data_enc_i (
        .gnt_i       (data_gnt_o),
        .rvalid_i    (data_rvalid_o),
        .r_i         (data_r_o),
        .gntpar_o    (data_gntpar_o),
        .rvalidpar_o (data_rvalidpar_o),
        .rchk_o      (data_rchk_o)
    );

endmodule

/* verilog/obi_port_arbiter.sv */
module obi_port_arbiter
    import obi_integ_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    // Instruction port
    input  logic     instr_req_i,
    input  logic     instr_bad_i,
    input  obi_req_t instr_a_i,
    // Data port
    input  logic     data_req_i,
    input  logic     data_bad_i,
    input  obi_req_t data_a_i,
    // Grants, same cycle as req
    output logic     instr_gnt_o,
    output logic     data_gnt_o,
    // Memory side
    output logic     mem_en_o,
    output logic     mem_suppress_o,
    output obi_req_t mem_a_o,
    input  obi_rsp_t mem_rsp_i,
    // Responses steered back to the ports
    output logic     instr_rvalid_o,
    output logic     data_rvalid_o,
    output obi_rsp_t instr_r_o,
    output obi_rsp_t data_r_o
);

    // --------------------------------------------------
    // Fixed priority grant
    // --------------------------------------------------

    // Bit 0 is instr, bit 1 is data
    logic [1:0] gnt_vec;
    logic [1:0] winner_q;

    // Data always wins
    assign gnt_vec[1] = data_req_i;
    // Instr only on a cycle without data
    assign gnt_vec[0] = instr_req_i & ~data_req_i;

    assign data_gnt_o  = gnt_vec[1];
    assign instr_gnt_o = gnt_vec[0];

    // Memory is busy whenever someone is granted
    assign mem_en_o = |gnt_vec;

    // Address phase and suppress follow the winner
    assign mem_a_o        = gnt_vec[1] ? data_a_i : instr_a_i;
    assign mem_suppress_o = gnt_vec[1] ? data_bad_i : instr_bad_i;

    // --------------------------------------------------
    // Winner tracking
    // --------------------------------------------------

    // Remembers the granted port for the response cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            winner_q <= 2'b00;
        end else begin
            winner_q <= gnt_vec;
        end
    end

    // rvalid one cycle after the granting edge
    assign instr_rvalid_o = winner_q[0];
    assign data_rvalid_o  = winner_q[1];

    // Idle port sees a zero response
    assign instr_r_o = winner_q[0] ? mem_rsp_i : '0;
    assign data_r_o  = winner_q[1] ? mem_rsp_i : '0;

endmodule

/* verilog/obi_req_checker.sv */
module obi_req_checker
    import obi_integ_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Requester side of one port
    input  logic      req_i,
    input  logic      reqpar_i,
    input  obi_req_t  a_i,
    input  obi_achk_t achk_i,
    // Marks the present request for suppression
    output logic      req_bad_o,
    // Registered fault pulses
    output logic      alert_major_o,
    output logic      alert_minor_o
);

    // --------------------------------------------------
    // Check bit recomputation
    // --------------------------------------------------
    obi_achk_t achk_calc;
    logic      achk_err;
    logic      par_err;
    logic      alert_major_q;
    logic      alert_minor_q;

    // One parity bit per address byte
    assign achk_calc[0] = ^a_i.addr[7:0];
    assign achk_calc[1] = ^a_i.addr[15:8];
    assign achk_calc[2] = ^a_i.addr[23:16];
    assign achk_calc[3] = ^a_i.addr[31:24];
    // Write enable folded together with the byte enables
    assign achk_calc[4] = ^{a_i.we, a_i.be};
    // Whole write payload
    assign achk_calc[5] = ^a_i.wdata;

    // Any bit off means the address phase was corrupted
    assign achk_err = (achk_calc != achk_i);

    // reqpar must always be the inverse of req
    assign par_err = (reqpar_i == req_i);

    // Only a present request is suppressed
    // A bare parity fault with req low only alerts
    assign req_bad_o = req_i & (achk_err | par_err);

    // --------------------------------------------------
    // Alert registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            alert_major_q <= 1'b0;
            alert_minor_q <= 1'b0;
        end else begin
            // One pulse per offending cycle
            alert_major_q <= par_err;
            // achk is only meaningful with req high
            alert_minor_q <= req_i & achk_err;
        end
    end

    assign alert_major_o = alert_major_q;
    assign alert_minor_o = alert_minor_q;

endmodule

/* verilog/obi_rsp_encoder.sv */
module obi_rsp_encoder
    import obi_integ_pkg::*;
(
    // Handshake strobes of one port
    input  logic      gnt_i,
    input  logic      rvalid_i,
    // Response going back to the port
    input  obi_rsp_t  r_i,
    // Integrity outputs
    output logic      gntpar_o,
    output logic      rvalidpar_o,
    output obi_rchk_t rchk_o
);

    // --------------------------------------------------
    // Strobe parity
    // --------------------------------------------------

    // Odd parity on each strobe, so idle reads as 1
    assign gntpar_o    = ~gnt_i;
    assign rvalidpar_o = ~rvalid_i;

    // --------------------------------------------------
    // Response check bits
    // --------------------------------------------------

    // One parity bit per rdata byte
    for (genvar b = 0; b < 4; b++) begin : g_byte_par
        assign rchk_o[b] = ^r_i.rdata[8*b +: 8];
    end

    // err carried straight through
    assign rchk_o[4] = r_i.err;

endmodule

/* verilog/obi_sram.sv */
`include "obi_integ_config.svh"

module obi_sram
    import obi_integ_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    // Access strobe from the arbiter
    input  logic     en_i,
    // Request failed its integrity checks
    input  logic     suppress_i,
    input  obi_req_t a_i,
    // Registered response
    output obi_rsp_t rsp_o
);

    localparam int unsigned DEPTH = 1 << `OBI_MEM_AW;

    // --------------------------------------------------
    // Storage and decode
    // --------------------------------------------------
    obi_word_u              mem [0:DEPTH-1];
    obi_word_u              wdata_w;
    logic [`OBI_MEM_AW-1:0] word_idx;
    logic                   in_range;
    logic                   acc_ok;
    logic                   wr_ok;
    logic [31:0]            rdata_q;
    logic                   err_q;

    // Word address, byte offset dropped
    assign word_idx = a_i.addr[`OBI_MEM_AW+1:2];

    // Upper address bits must be clear
    assign in_range = (a_i.addr[`OBI_ADDR_W-1:`OBI_MEM_AW+2] == '0);

    // Good access, in range and not flagged
    assign acc_ok = in_range & ~suppress_i;
    assign wr_ok  = en_i & a_i.we & acc_ok;

    // Write payload split into byte lanes
    assign wdata_w.word = a_i.wdata;

    // --------------------------------------------------
    // Byte enable write
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (a_i.be[b]) begin
                    mem[word_idx].bytes[b] <= wdata_w.bytes[b];
                end
            end
        end
    end

    // --------------------------------------------------
    // Read data and error register
    // --------------------------------------------------

    // Old contents on a write, zero on an error
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_q <= acc_ok ? mem[word_idx].word : 32'h0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else if (en_i) begin
            err_q <= ~acc_ok;
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.err   = err_q;

endmodule
